//--- rtl/hisPkg.sv
package hisPkg;

    // histogram geometry
    localparam int BIN_BITS = 4;
    localparam int BIN_NUM = 2 ** BIN_BITS;

    // acquisition geometry, one frame = PIXEL_NUM * DATA_NUM * ACQ_NUM samples
    localparam int PIXEL_NUM = 4;
    localparam int PIXEL_BITS = $clog2(PIXEL_NUM);
    localparam int DATA_NUM = 4;
    localparam int DATA_BITS = $clog2(DATA_NUM);
    localparam int ACQ_NUM = 3;
    localparam int ACQ_BITS = $clog2(ACQ_NUM);

    // one count slot per pixel and bin
    localparam int ENTRY_NUM = PIXEL_NUM * BIN_NUM;

    // count and fine-scale window widths
    localparam int COUNT_BITS = 8;
    localparam int WIN_BITS = 8;
    localparam int WIN_SHIFT = WIN_BITS - BIN_BITS;
    localparam int WIN_TOP = 2 ** WIN_BITS - 1;
    localparam int HALF_SPAN = 2 ** (BIN_BITS - 1);

    typedef logic [BIN_BITS-1:0] binIdxT;
    typedef logic [PIXEL_BITS-1:0] pixelIdxT;
    typedef logic [DATA_BITS-1:0] sampleIdxT;
    typedef logic [ACQ_BITS-1:0] acqIdxT;
    typedef logic [PIXEL_BITS+BIN_BITS-1:0] entryIdxT;
    typedef logic [COUNT_BITS-1:0] countT;
    typedef logic [WIN_BITS-1:0] winT;

    // one histogram increment, count is the value after the increment
    typedef struct packed {
        pixelIdxT pixel;
        binIdxT bin;
        countT count;
    } binUpdateT;

    // result of one pixel at frame end
    typedef struct packed {
        binIdxT peakBin;
        countT peakCount;
        winT winLo;
        winT winHi;
    } peakReportT;

    typedef peakReportT [PIXEL_NUM-1:0] peakReportArrT;

    // collect samples, or spend one cycle publishing the frame
    typedef enum logic {
        COLLECT,
        REPORT
    } frameStateT;

endpackage

//--- rtl/sampleCounter.sv
module sampleCounter (
    input  logic             clk,
    input  logic             combin_res,
    input  logic             accept,
    output hisPkg::pixelIdxT pixelIdx,
    output logic             frameEnd
);

    // sample within pixel, pixel within acquisition, acquisition within frame
    hisPkg::sampleIdxT sampleCnt;
    hisPkg::pixelIdxT pixelCnt;
    hisPkg::acqIdxT acqCnt;

    logic lastSample;
    logic lastPixel;
    logic lastAcq;

    // wrap points of each counter
    assign lastSample = (sampleCnt == hisPkg::sampleIdxT'(hisPkg::DATA_NUM - 1));
    assign lastPixel = (pixelCnt == hisPkg::pixelIdxT'(hisPkg::PIXEL_NUM - 1));
    assign lastAcq = (acqCnt == hisPkg::acqIdxT'(hisPkg::ACQ_NUM - 1));

    // high in the cycle of the frame's final accepted sample
    assign frameEnd = accept && lastSample && lastPixel && lastAcq;

    assign pixelIdx = pixelCnt;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixelCnt <= '0;
            acqCnt <= '0;
        end else if (accept) begin
            // innermost counter carries into pixel on wrap
            if (!lastSample) begin
                sampleCnt <= sampleCnt + 1'b1;
            end else begin
                sampleCnt <= '0;
                if (!lastPixel) begin
                    pixelCnt <= pixelCnt + 1'b1;
                end else begin
                    pixelCnt <= '0;
                    // acquisition wraps at frame end
                    if (!lastAcq) begin
                        acqCnt <= acqCnt + 1'b1;
                    end else begin
                        acqCnt <= '0;
                    end
                end
            end
        end
    end

    // counters stay inside their ranges
    counterRange: assert property (
        @(posedge clk) disable iff (!combin_res)
        (sampleCnt < hisPkg::DATA_NUM) && (pixelCnt < hisPkg::PIXEL_NUM)
            && (acqCnt < hisPkg::ACQ_NUM)
    ) else $error("sample counter out of range");

endmodule

//--- rtl/hisFrameFsm.sv
module hisFrameFsm (
    input  logic clk,
    input  logic combin_res,
    input  logic wrEn,
    input  logic frameEnd,
    output logic accept,
    output logic clearHist,
    output logic peakDone,
    output logic hisNum
);

    hisPkg::frameStateT state;
    hisPkg::frameStateT nextState;

    // samples only count while collecting, REPORT drops them
    assign accept = wrEn && (state == hisPkg::COLLECT);

    // the report cycle both announces peaks and wipes the histogram
    assign peakDone = (state == hisPkg::REPORT);
    assign clearHist = (state == hisPkg::REPORT);

    always_comb begin
        nextState = state;
        case (state)
            hisPkg::COLLECT: begin
                if (frameEnd) begin
                    nextState = hisPkg::REPORT;
                end
            end
            // exactly one cycle here
            hisPkg::REPORT: begin
                nextState = hisPkg::COLLECT;
            end
            default: begin
                nextState = hisPkg::COLLECT;
            end
        endcase
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state <= hisPkg::COLLECT;
            hisNum <= 1'b0;
        end else begin
            state <= nextState;
            // histogram number flips on entering REPORT
            if (state == hisPkg::COLLECT && frameEnd) begin
                hisNum <= ~hisNum;
            end
        end
    end

    // single-cycle done strobe
    donePulse: assert property (
        @(posedge clk) disable iff (!combin_res)
        peakDone |=> !peakDone
    ) else $error("peakDone held for more than one cycle");

    // frame end leads through REPORT and back to COLLECT
    reportReturn: assert property (
        @(posedge clk) disable iff (!combin_res)
        frameEnd |=> (state == hisPkg::REPORT) ##1 (state == hisPkg::COLLECT)
    ) else $error("REPORT did not return to COLLECT");

endmodule

//--- rtl/binStore.sv
module binStore (
    input  logic              clk,
    input  logic              combin_res,
    input  logic              accept,
    input  logic              clearHist,
    input  hisPkg::pixelIdxT  pixelIdx,
    input  hisPkg::binIdxT    addr,
    output hisPkg::binUpdateT update,
    output logic              updValid,
    output hisPkg::countT     binCounts
);

    // count memory with one slot per pixel and bin
    hisPkg::countT cntMem [hisPkg::ENTRY_NUM];

    // entry holds a count of the current frame
    logic [hisPkg::ENTRY_NUM-1:0] validFlags;

    hisPkg::entryIdxT entry;
    hisPkg::countT oldCount;
    hisPkg::countT newCount;

    // pixel selects the histogram, addr the bin inside it
    assign entry = {pixelIdx, addr};

    // stale entries read as empty
    assign oldCount = validFlags[entry] ? cntMem[entry] : '0;
    assign newCount = oldCount + 1'b1;

    // same-cycle update for the peak finder
    always_comb begin
        update.pixel = pixelIdx;
        update.bin = addr;
        update.count = newCount;
    end

    assign updValid = accept;

    // control state and the visible count
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            validFlags <= '0;
            binCounts <= '0;
        end else begin
            if (clearHist) begin
                // whole histogram emptied in one cycle
                validFlags <= '0;
            end else if (accept) begin
                validFlags[entry] <= 1'b1;
            end
            // holds until the next accepted sample
            if (accept) begin
                binCounts <= newCount;
            end
        end
    end

    // count storage
    always_ff @(posedge clk) begin
        if (accept) begin
            cntMem[entry] <= newCount;
        end
    end

    // an accepted sample never shows up as an empty bin
    noWrap: assert property (
        @(posedge clk) disable iff (!combin_res)
        accept |=> (binCounts != '0)
    ) else $error("bin count wrapped to zero");

endmodule

//--- rtl/peakFinder.sv
module peakFinder (
    input  logic                  clk,
    input  logic                  combin_res,
    input  hisPkg::binUpdateT     update,
    input  logic                  updValid,
    input  logic                  frameEnd,
    input  logic                  clearHist,
    output hisPkg::peakReportArrT peaks
);

    // running maximum per pixel and the bin that reached it first
    hisPkg::countT maxCount [hisPkg::PIXEL_NUM];
    hisPkg::binIdxT maxBin [hisPkg::PIXEL_NUM];

    // maxima including the update of this cycle
    hisPkg::countT curCount [hisPkg::PIXEL_NUM];
    hisPkg::binIdxT curBin [hisPkg::PIXEL_NUM];
    logic [hisPkg::PIXEL_NUM-1:0] newMax;

    // coarse peak bin to fine-scale window, clamped at both ends
    function automatic hisPkg::peakReportT makeReport(
        input hisPkg::binIdxT bin,
        input hisPkg::countT count
    );
        hisPkg::peakReportT rep;
        hisPkg::winT center;
        center = hisPkg::winT'(bin) << hisPkg::WIN_SHIFT;
        rep.peakBin = bin;
        rep.peakCount = count;
        if (center >= hisPkg::WIN_TOP - hisPkg::HALF_SPAN) begin
            // top edge pinned to full scale
            rep.winHi = hisPkg::winT'(hisPkg::WIN_TOP);
            rep.winLo = hisPkg::winT'(hisPkg::WIN_TOP - 2 * hisPkg::HALF_SPAN);
        end else if (center <= hisPkg::HALF_SPAN) begin
            // bottom edge pinned to zero
            rep.winLo = '0;
            rep.winHi = hisPkg::winT'(2 * hisPkg::HALF_SPAN);
        end else begin
            rep.winLo = hisPkg::winT'(center - hisPkg::HALF_SPAN);
            rep.winHi = hisPkg::winT'(center + hisPkg::HALF_SPAN);
        end
        return rep;
    endfunction

    // strictly greater only, so ties keep the earlier bin
    always_comb begin
        for (int p = 0; p < hisPkg::PIXEL_NUM; p++) begin
            newMax[p] = updValid && (update.pixel == hisPkg::pixelIdxT'(p))
                && (update.count > maxCount[p]);
            curCount[p] = newMax[p] ? update.count : maxCount[p];
            curBin[p] = newMax[p] ? update.bin : maxBin[p];
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            maxCount <= '{default: '0};
            maxBin <= '{default: '0};
            peaks <= '0;
        end else begin
            for (int p = 0; p < hisPkg::PIXEL_NUM; p++) begin
                if (clearHist) begin
                    maxCount[p] <= '0;
                    maxBin[p] <= '0;
                end else begin
                    maxCount[p] <= curCount[p];
                    maxBin[p] <= curBin[p];
                end
                // publish with the final sample folded in
                if (frameEnd) begin
                    peaks[p] <= makeReport(curBin[p], curCount[p]);
                end
            end
        end
    end

    // maxima are always wiped right after a report
    clearAfterReport: assert property (
        @(posedge clk) disable iff (!combin_res)
        frameEnd |=> clearHist
    ) else $error("frame end not followed by a clear");

endmodule

//--- rtl/hisBuilderTop.sv
module hisBuilderTop (
    input  logic                  clk,
    input  logic                  combin_res,
    input  logic                  wrEn,
    input  hisPkg::binIdxT        addr,
    output hisPkg::countT         binCounts,
    output logic                  peakDone,
    output logic                  hisNum,
    output hisPkg::peakReportArrT peaks
);

    // frame control
    logic accept;
    logic clearHist;
    logic frameEnd;
    hisPkg::pixelIdxT pixelIdx;

    // histogram increment toward the peak finder
    hisPkg::binUpdateT update;
    logic updValid;

    hisFrameFsm fsm0 (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .frameEnd   (frameEnd),
        .accept     (accept),
        .clearHist  (clearHist),
        .peakDone   (peakDone),
        .hisNum     (hisNum)
    );

    sampleCounter counter0 (
        .clk        (clk),
        .combin_res (combin_res),
        .accept     (accept),
        .pixelIdx   (pixelIdx),
        .frameEnd   (frameEnd)
    );

    binStore store0 (
        .clk        (clk),
        .combin_res (combin_res),
        .accept     (accept),
        .clearHist  (clearHist),
        .pixelIdx   (pixelIdx),
        .addr       (addr),
        .update     (update),
        .updValid   (updValid),
        .binCounts  (binCounts)
    );

    peakFinder finder0 (
        .clk        (clk),
        .combin_res (combin_res),
        .update     (update),
        .updValid   (updValid),
        .frameEnd   (frameEnd),
        .clearHist  (clearHist),
        .peaks      (peaks)
    );

endmodule

//--- verification/tbClock.sv
module tbClock (
    output logic clk,
    output logic combin_res
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD = 2;
    localparam int RESET_CYCLES = 3;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // release shortly after the third rising edge
    initial begin
        combin_res = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 combin_res = 1'b1;
    end

endmodule

//--- verification/hisChecker.sv
module hisChecker (
    input  logic                  clk,
    input  logic                  combin_res,
    input  logic                  wrEn,
    input  hisPkg::binIdxT        addr,
    input  hisPkg::countT         binCounts,
    input  logic                  peakDone,
    input  logic                  hisNum,
    input  hisPkg::peakReportArrT peaks,
    output int                    errCount,
    output int                    checkCnt,
    output int                    framesDone
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int FRAME_SAMPLES = hisPkg::PIXEL_NUM * hisPkg::DATA_NUM * hisPkg::ACQ_NUM;
    localparam int HALF = 8;

    // model histogram and running maxima
    int hist [hisPkg::PIXEL_NUM][hisPkg::BIN_NUM];
    int maxCnt [hisPkg::PIXEL_NUM];
    int maxBin [hisPkg::PIXEL_NUM];

    // expected published reports
    int expBin [hisPkg::PIXEL_NUM];
    int expPeak [hisPkg::PIXEL_NUM];
    int expLo [hisPkg::PIXEL_NUM];
    int expHi [hisPkg::PIXEL_NUM];

    int expCount;
    int sampleNo;
    logic expHisNum;
    // cycle after a frame's last accepted sample
    logic inReport;

    task automatic compareValue(input string name, input int expected, input int actual);
        checkCnt++;
        if (expected != actual) begin
            errCount++;
            $display("ERROR %s: expected %0d, actual %0d at %0t", name, expected, actual,
                $time);
        end
    endtask

    task automatic clearHistogram();
        for (int p = 0; p < hisPkg::PIXEL_NUM; p++) begin
            for (int b = 0; b < hisPkg::BIN_NUM; b++) begin
                hist[p][b] = 0;
            end
            maxCnt[p] = 0;
            maxBin[p] = 0;
        end
    endtask

    // window around bin * 16 pinned at both ends of the 0..255 scale
    task automatic publishFrame();
        int center;
        for (int p = 0; p < hisPkg::PIXEL_NUM; p++) begin
            center = maxBin[p] * 16;
            expBin[p] = maxBin[p];
            expPeak[p] = maxCnt[p];
            if (center >= 255 - HALF) begin
                expHi[p] = 255;
                expLo[p] = 255 - 2 * HALF;
            end else if (center <= HALF) begin
                expLo[p] = 0;
                expHi[p] = 2 * HALF;
            end else begin
                expLo[p] = center - HALF;
                expHi[p] = center + HALF;
            end
        end
    endtask

    task automatic checkOutputs();
        compareValue("binCounts", expCount, binCounts);
        compareValue("peakDone", inReport, peakDone);
        compareValue("hisNum", expHisNum, hisNum);
        // reports must also hold between frames
        for (int p = 0; p < hisPkg::PIXEL_NUM; p++) begin
            compareValue($sformatf("peakBin[%0d]", p), expBin[p], peaks[p].peakBin);
            compareValue($sformatf("peakCount[%0d]", p), expPeak[p], peaks[p].peakCount);
            compareValue($sformatf("winLo[%0d]", p), expLo[p], peaks[p].winLo);
            compareValue($sformatf("winHi[%0d]", p), expHi[p], peaks[p].winHi);
        end
        if (inReport) begin
            framesDone++;
        end
    endtask

    task automatic advanceModel();
        int pixel;
        if (inReport) begin
            // wrEn here is dropped and the histogram starts over
            clearHistogram();
            inReport = 1'b0;
        end else if (wrEn) begin
            pixel = (sampleNo / hisPkg::DATA_NUM) % hisPkg::PIXEL_NUM;
            hist[pixel][addr]++;
            expCount = hist[pixel][addr];
            // strictly greater so the first bin to reach the max wins
            if (hist[pixel][addr] > maxCnt[pixel]) begin
                maxCnt[pixel] = hist[pixel][addr];
                maxBin[pixel] = addr;
            end
            sampleNo++;
            if (sampleNo == FRAME_SAMPLES) begin
                publishFrame();
                sampleNo = 0;
                expHisNum = ~expHisNum;
                inReport = 1'b1;
            end
        end
    endtask

    initial begin
        errCount = 0;
        checkCnt = 0;
        framesDone = 0;
    end

    // sampled mid-cycle where inputs and registered outputs are settled
    always @(negedge clk) begin
        if (combin_res !== 1'b1) begin
            clearHistogram();
            for (int p = 0; p < hisPkg::PIXEL_NUM; p++) begin
                expBin[p] = 0;
                expPeak[p] = 0;
                expLo[p] = 0;
                expHi[p] = 0;
            end
            expCount = 0;
            sampleNo = 0;
            expHisNum = 1'b0;
            inReport = 1'b0;
        end else begin
            checkOutputs();
            advanceModel();
        end
    end

endmodule

//--- verification/tbHisBuilder.sv
module tbHisBuilder;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SEED = 97963;
    localparam int FRAME_NUM = 5;
    localparam int FRAME_SAMPLES = hisPkg::PIXEL_NUM * hisPkg::DATA_NUM * hisPkg::ACQ_NUM;
    // 3 of 4 cycles carry a sample, so 4 cycles per sample is ample
    localparam int TIMEOUT_CYCLES = FRAME_NUM * FRAME_SAMPLES * 4 + 50;

    logic clk;
    logic combin_res;
    logic wrEn;
    hisPkg::binIdxT addr;
    hisPkg::countT binCounts;
    logic peakDone;
    logic hisNum;
    hisPkg::peakReportArrT peaks;

    int errCount;
    int checkCnt;
    int framesDone;
    int cycleCnt;
    // samples the DUT will accept for tracking pixel and frame of the skew
    int sentCnt;

    tbClock clkGen0 (
        .clk        (clk),
        .combin_res (combin_res)
    );

    hisBuilderTop dut0 (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .addr       (addr),
        .binCounts  (binCounts),
        .peakDone   (peakDone),
        .hisNum     (hisNum),
        .peaks      (peaks)
    );

    hisChecker checker0 (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .addr       (addr),
        .binCounts  (binCounts),
        .peakDone   (peakDone),
        .hisNum     (hisNum),
        .peaks      (peaks),
        .errCount   (errCount),
        .checkCnt   (checkCnt),
        .framesDone (framesDone)
    );

    // favored bin moves per pixel and frame and hits bin 0 and bin 15
    task automatic driveSample();
        int frameIdx;
        int pixel;
        int favBin;
        logic take;
        take = ($urandom % 4) != 0;
        frameIdx = sentCnt / FRAME_SAMPLES;
        pixel = (sentCnt / hisPkg::DATA_NUM) % hisPkg::PIXEL_NUM;
        favBin = (frameIdx * 5 + pixel * 4) % hisPkg::BIN_NUM;
        wrEn = take;
        if (($urandom % 2) == 0) begin
            addr = hisPkg::binIdxT'(favBin);
        end else begin
            addr = hisPkg::binIdxT'($urandom % hisPkg::BIN_NUM);
        end
        // REPORT cycle drops the sample
        if (take && !peakDone) begin
            sentCnt++;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        wrEn = 1'b0;
        addr = '0;
        sentCnt = 0;
        @(posedge combin_res);
        while (framesDone < FRAME_NUM) begin
            @(posedge clk);
            #1;
            driveSample();
        end
        wrEn = 1'b0;
        repeat (2) @(posedge clk);
        $display("checks: %0d, errors: %0d, frames: %0d", checkCnt, errCount, framesDone);
        if (errCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // run limit
    initial begin
        cycleCnt = 0;
    end

    always @(posedge clk) begin
        cycleCnt = cycleCnt + 1;
        if (cycleCnt >= TIMEOUT_CYCLES) begin
            $display("timeout: only %0d of %0d frames finished within %0d cycles",
                framesDone, FRAME_NUM, TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

endmodule

//--- hisBuilder.f
rtl/hisPkg.sv
rtl/sampleCounter.sv
rtl/hisFrameFsm.sv
rtl/binStore.sv
rtl/peakFinder.sv
rtl/hisBuilderTop.sv
verification/tbClock.sv
verification/hisChecker.sv
verification/tbHisBuilder.sv

//--- Bender.yml
package:
  name: hisBuilder

sources:
  - rtl/hisPkg.sv
  - rtl/sampleCounter.sv
  - rtl/hisFrameFsm.sv
  - rtl/binStore.sv
  - rtl/peakFinder.sv
  - rtl/hisBuilderTop.sv
  - target: test
    files:
      - verification/tbClock.sv
      - verification/hisChecker.sv
      - verification/tbHisBuilder.sv
